// ==== bmu_cfg.svh ====
/* Bit-manipulation unit sizing
   Data width, lane count and issue tag width */

`ifndef BMU_CFG_SVH
`define BMU_CFG_SVH

// RV32 only
`define BMU_XLEN  32

// Lanes in flight
`define BMU_LANES 4

// Round-robin pointer width, must cover BMU_LANES
`define BMU_TAGW  2

`endif

// ==== bmu_pkg.sv ====
/* Bit-manipulation unit types
   Instruction views, request and result bundles, decoded operation */

`default_nettype none
`include "bmu_cfg.svh"

package bmu_pkg;

  //////////////////////////////////////////////////
  // Instruction word layouts
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeFields_t;

  typedef struct packed {
    logic [11:0] imm12;                     // [11:5] op select, [4:0] shamt or bit index
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeFields_t;

  // Same 32 bits, read as R-type or I-type
  typedef union packed {
    logic [31:0]  word;
    rTypeFields_t rType;
    iTypeFields_t iType;
  } bmuInstr_u;

  //////////////////////////////////////////////////
  // Transport bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    bmuInstr_u             instr;
    logic [`BMU_XLEN-1:0]  rs1Val;
    logic [`BMU_XLEN-1:0]  rs2Val;
  } bmuReq_t;                               // 96 bits

  typedef struct packed {
    logic [4:0]            rd;
    logic [`BMU_XLEN-1:0]  value;
  } bmuRes_t;                               // 37 bits

  // Decoded operation, opNone gives zero
  typedef enum logic [4:0] {
    opNone,
    opSh1add, opSh2add, opSh3add,           // Zba
    opAndn, opOrn, opXnor,
    opClz, opCtz, opCpop,
    opMin, opMinu, opMax, opMaxu,
    opSextb, opSexth, opZexth,
    opRol, opRor, opOrcb, opRev8,           // Zbb
    opBset, opBclr, opBinv, opBext,         // Zbs, reg and imm forms
    opClmul, opClmulh, opClmulr             // Zbc
  } bmuOp_e;

endpackage

`default_nettype wire

// ==== bitCount.sv ====
/* Bit counter
   Leading zeros, trailing zeros and population count of one word */

`timescale 1ns/1ps
`default_nettype none

module bitCount (
  input  logic [31:0] a,
  output logic [5:0]  lzc,
  output logic [5:0]  tzc,
  output logic [5:0]  popc
);

  logic [31:0] c1, c2, c4, c8, c16;        // Partial sums per field

  // Priority scans, zero word gives 32
  always_comb begin
    lzc = 6'd32;
    tzc = 6'd32;
    for (int k = 0; k < 32; k++) begin
      if (a[k]) lzc = 6'(31 - k);          // Highest set bit wins
    end
    for (int k = 31; k >= 0; k--) begin
      if (a[k]) tzc = 6'(k);               // Lowest set bit wins
    end
  end

  // Adder tree, fields double each level
  assign c1  = (a  & 32'h5555_5555) + ((a  >> 1)  & 32'h5555_5555);
  assign c2  = (c1 & 32'h3333_3333) + ((c1 >> 2)  & 32'h3333_3333);
  assign c4  = (c2 & 32'h0f0f_0f0f) + ((c2 >> 4)  & 32'h0f0f_0f0f);
  assign c8  = (c4 & 32'h00ff_00ff) + ((c4 >> 8)  & 32'h00ff_00ff);
  assign c16 = (c8 & 32'h0000_ffff) + ((c8 >> 16) & 32'h0000_ffff);
  assign popc = c16[5:0];                  // Max 32 fits in 6 bits

endmodule

`default_nettype wire

// ==== bitmanipAlu.sv ====
/* Bit-manipulation datapath
   Zba, Zbb, Zbs and Zbc operations on two operands, one result per op */

`timescale 1ns/1ps
`default_nettype none
`include "bmu_cfg.svh"

module bitmanipAlu import bmu_pkg::*; (
  input  bmuOp_e               op,
  input  logic [`BMU_XLEN-1:0] a,
  input  logic [`BMU_XLEN-1:0] b,
  output logic [`BMU_XLEN-1:0] result
);

  localparam int ShW = $clog2(`BMU_XLEN);

  logic [`BMU_XLEN-1:0]   preShiftA;       // a << 1..3 for sh*add
  logic [`BMU_XLEN-1:0]   bitMask;         // One-hot from b index
  logic [2*`BMU_XLEN-1:0] rolWide, rorWide;
  logic [`BMU_XLEN-1:0]   orcb, rev8;
  logic                   lt, ltu;
  logic [`BMU_XLEN-1:0]   clmulLow, clmulRev, clmulHigh;
  logic [5:0]             lzc, tzc, popc;

  // Carry-less product, low half only
  function automatic logic [`BMU_XLEN-1:0] clmulLo(input logic [`BMU_XLEN-1:0] x,
                                                   input logic [`BMU_XLEN-1:0] y);
    logic [`BMU_XLEN-1:0] acc;
    acc = '0;
    for (int k = 0; k < `BMU_XLEN; k++) begin
      if (y[k]) acc = acc ^ (x << k);
    end
    return acc;
  endfunction

  function automatic logic [`BMU_XLEN-1:0] bitRev(input logic [`BMU_XLEN-1:0] x);
    logic [`BMU_XLEN-1:0] r;
    for (int k = 0; k < `BMU_XLEN; k++) begin
      r[k] = x[`BMU_XLEN-1-k];
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Operand preparation
  //////////////////////////////////////////////////

  always_comb begin
    case (op)
      opSh1add: preShiftA = a << 1;
      opSh2add: preShiftA = a << 2;
      opSh3add: preShiftA = a << 3;
      default:  preShiftA = a;
    endcase
  end

  assign bitMask = `BMU_XLEN'(1) << b[ShW-1:0];   // Zbs single bit

  // Rotates through a doubled word
  assign rolWide = {a, a} << b[ShW-1:0];
  assign rorWide = {a, a} >> b[ShW-1:0];

  // Byte-wise ops
  always_comb begin
    for (int k = 0; k < `BMU_XLEN / 8; k++) begin
      orcb[8*k +: 8] = {8{|a[8*k +: 8]}};
      rev8[8*k +: 8] = a[`BMU_XLEN-8-8*k +: 8];
    end
  end

  assign lt  = $signed(a) < $signed(b);
  assign ltu = a < b;

  // Zbc, reversed form from reversed operands
  assign clmulLow  = clmulLo(a, b);
  assign clmulRev  = bitRev(clmulLo(bitRev(a), bitRev(b)));
  assign clmulHigh = {1'b0, clmulRev[`BMU_XLEN-1:1]};

  bitCount bitCount_inst (.a(a), .lzc(lzc), .tzc(tzc), .popc(popc));

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb begin
    case (op)
      opSh1add, opSh2add, opSh3add: result = preShiftA + b;
      opAndn:   result = a & ~b;
      opOrn:    result = a | ~b;
      opXnor:   result = ~(a ^ b);
      opClz:    result = `BMU_XLEN'(lzc);
      opCtz:    result = `BMU_XLEN'(tzc);
      opCpop:   result = `BMU_XLEN'(popc);
      opMin:    result = lt  ? a : b;
      opMinu:   result = ltu ? a : b;
      opMax:    result = lt  ? b : a;
      opMaxu:   result = ltu ? b : a;
      opSextb:  result = {{(`BMU_XLEN-8){a[7]}}, a[7:0]};
      opSexth:  result = {{(`BMU_XLEN-16){a[15]}}, a[15:0]};
      opZexth:  result = {{(`BMU_XLEN-16){1'b0}}, a[15:0]};
      opRol:    result = rolWide[2*`BMU_XLEN-1:`BMU_XLEN];
      opRor:    result = rorWide[`BMU_XLEN-1:0];
      opOrcb:   result = orcb;
      opRev8:   result = rev8;
      opBset:   result = a | bitMask;
      opBclr:   result = a & ~bitMask;
      opBinv:   result = a ^ bitMask;
      opBext:   result = `BMU_XLEN'(|(a & bitMask));
      opClmul:  result = clmulLow;
      opClmulh: result = clmulHigh;
      opClmulr: result = clmulRev;
      default:  result = '0;               // Unrecognised gives zero
    endcase
  end

endmodule

`default_nettype wire

// ==== bmuLane.sv ====
/* Execution lane
   Holds one request, decodes it, computes through the ALU and
   keeps the result until the collector retires it */

`timescale 1ns/1ps
`default_nettype none
`include "bmu_cfg.svh"

module bmuLane import bmu_pkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    issue,
  input  bmuReq_t laneReq,
  input  logic    retire,                  // Release pulse from the collector
  output logic    busy,
  output logic    done,
  output bmuRes_t laneRes
);

  bmuReq_t              reqQ;              // Held request
  bmuOp_e               op;
  logic                 useImm;            // Shamt from imm12 replaces rs2Val
  logic [`BMU_XLEN-1:0] opB, aluResult;
  logic [11:0]          imm;

  assign imm = reqQ.instr.iType.imm12;

  // Lane occupancy
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (issue) begin
      busy <= 1'b1;
    end else if (retire) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (busy) begin
      done <= 1'b1;                        // Result lands one cycle after busy
    end
  end

  always_ff @(posedge clk) begin
    if (issue) reqQ <= laneReq;
    if (busy && !done) laneRes <= '{rd: reqQ.instr.rType.rd, value: aluResult};
  end

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  always_comb begin
    op     = opNone;
    useImm = 1'b0;
    case (reqQ.instr.rType.opcode)
      7'b0110011: begin                    // OP, R-type view
        case ({reqQ.instr.rType.funct7, reqQ.instr.rType.funct3})
          {7'b0010000, 3'b010}: op = opSh1add;
          {7'b0010000, 3'b100}: op = opSh2add;
          {7'b0010000, 3'b110}: op = opSh3add;
          {7'b0100000, 3'b111}: op = opAndn;
          {7'b0100000, 3'b110}: op = opOrn;
          {7'b0100000, 3'b100}: op = opXnor;
          {7'b0000101, 3'b100}: op = opMin;
          {7'b0000101, 3'b101}: op = opMinu;
          {7'b0000101, 3'b110}: op = opMax;
          {7'b0000101, 3'b111}: op = opMaxu;
          {7'b0000101, 3'b001}: op = opClmul;
          {7'b0000101, 3'b010}: op = opClmulr;
          {7'b0000101, 3'b011}: op = opClmulh;
          {7'b0110000, 3'b001}: op = opRol;
          {7'b0110000, 3'b101}: op = opRor;
          {7'b0010100, 3'b001}: op = opBset;
          {7'b0100100, 3'b001}: op = opBclr;
          {7'b0110100, 3'b001}: op = opBinv;
          {7'b0100100, 3'b101}: op = opBext;
          {7'b0000100, 3'b100}: if (reqQ.instr.rType.rs2 == 5'd0) op = opZexth;
          default: ;
        endcase
      end
      7'b0010011: begin                    // OP-IMM, I-type view
        useImm = 1'b1;
        case ({imm[11:5], reqQ.instr.iType.funct3})
          {7'b0110000, 3'b001}: begin      // Unary group by imm12[4:0]
            case (imm[4:0])
              5'd0:    op = opClz;
              5'd1:    op = opCtz;
              5'd2:    op = opCpop;
              5'd4:    op = opSextb;
              5'd5:    op = opSexth;
              default: op = opNone;
            endcase
          end
          {7'b0110000, 3'b101}: op = opRor;          // rori
          {7'b0010100, 3'b001}: op = opBset;
          {7'b0100100, 3'b001}: op = opBclr;
          {7'b0110100, 3'b001}: op = opBinv;
          {7'b0100100, 3'b101}: op = opBext;
          {7'b0010100, 3'b101}: if (imm[4:0] == 5'd7)  op = opOrcb;
          {7'b0110100, 3'b101}: if (imm[4:0] == 5'd24) op = opRev8;
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  assign opB = useImm ? {{(`BMU_XLEN-5){1'b0}}, imm[4:0]} : reqQ.rs2Val;

  bitmanipAlu bitmanipAlu_inst (
    .op    (op),
    .a     (reqQ.rs1Val),
    .b     (opB),
    .result(aluResult)
  );

endmodule

`default_nettype wire

// ==== bmuDispatch.sv ====
/* Request dispatcher
   Input four-phase req/ack and round-robin issue of requests into the lanes */

`timescale 1ns/1ps
`default_nettype none
`include "bmu_cfg.svh"

module bmuDispatch import bmu_pkg::*; (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  req,
  input  bmuReq_t               reqData,
  input  logic [`BMU_LANES-1:0] busy,
  output logic                  ack,
  output logic [`BMU_LANES-1:0] issue,
  output bmuReq_t               laneReq
);

  typedef enum logic [1:0] {sIdle, sAcked, sWaitLow} dispState_e;

  dispState_e           state;
  logic [`BMU_TAGW-1:0] ptr;               // Next lane to fill
  logic                 grant;             // Request present and target lane free

  assign grant = req && !busy[ptr];        // Busy lane holds ack back

  // Handshake FSM and round-robin pointer
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= sIdle;
      ptr   <= '0;
    end else begin
      case (state)
        sIdle:    if (grant) state <= sAcked;
        sAcked: begin                      // Issue cycle, move on to next lane
          ptr   <= (ptr == (`BMU_LANES - 1)) ? '0 : ptr + 1'b1;
          state <= req ? sWaitLow : sIdle;
        end
        sWaitLow: if (!req) state <= sIdle;
        default:  state <= sIdle;
      endcase
    end
  end

  // Request captured once, shared by all lanes
  always_ff @(posedge clk) begin
    if (state == sIdle && grant) laneReq <= reqData;
  end

  assign ack = (state != sIdle);           // High from issue until req seen low

  // One-hot issue pulse in the ack rising cycle
  always_comb begin
    issue = '0;
    if (state == sAcked) issue[ptr] = 1'b1;
  end

endmodule

`default_nettype wire

// ==== bmuCollect.sv ====
/* Result collector
   Drains the lanes in issue order over the output four-phase handshake */

`timescale 1ns/1ps
`default_nettype none
`include "bmu_cfg.svh"

module bmuCollect import bmu_pkg::*; (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic [`BMU_LANES-1:0] done,
  input  bmuRes_t               laneRes [`BMU_LANES],
  input  logic                  resAck,
  output logic                  resReq,
  output bmuRes_t               resData,
  output logic [`BMU_LANES-1:0] retire
);

  typedef enum logic [1:0] {sIdle, sPresent, sDrop, sRetire} collState_e;

  collState_e           state;
  logic [`BMU_TAGW-1:0] ptr;               // Expected lane, follows issue order

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= sIdle;
      ptr   <= '0;
    end else begin
      case (state)
        sIdle:    if (done[ptr]) state <= sPresent;
        sPresent: if (resAck)    state <= sDrop;    // Consumer took it
        sDrop:    if (!resAck)   state <= sRetire;  // Ack back low
        sRetire: begin
          ptr   <= (ptr == (`BMU_LANES - 1)) ? '0 : ptr + 1'b1;
          state <= sIdle;
        end
        default:  state <= sIdle;
      endcase
    end
  end

  // Snapshot of the lane result, stable through the handshake
  always_ff @(posedge clk) begin
    if (state == sIdle && done[ptr]) resData <= laneRes[ptr];
  end

  assign resReq = (state == sPresent);

  // Release pulse, frees the lane for the dispatcher
  always_comb begin
    retire = '0;
    if (state == sRetire) retire[ptr] = 1'b1;
  end

endmodule

`default_nettype wire

// ==== bmuTop.sv ====
/* Bit-manipulation coprocessor top
   Dispatcher, BMU_LANES execution lanes and in-order collector */

`timescale 1ns/1ps
`default_nettype none
`include "bmu_cfg.svh"

module bmuTop import bmu_pkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    req,
  input  bmuReq_t reqData,
  input  logic    resAck,
  output logic    ack,
  output logic    resReq,
  output bmuRes_t resData
);

  logic [`BMU_LANES-1:0] issue, busy, done, retire;
  bmuReq_t               laneReq;          // Shared, qualified by issue
  bmuRes_t               laneRes [`BMU_LANES];

  bmuDispatch bmuDispatch_inst (
    .clk(clk), .arstN(arstN), .req(req), .reqData(reqData),
    .busy(busy), .ack(ack), .issue(issue), .laneReq(laneReq)
  );

  // Lanes, filled and drained round-robin
  for (genvar i = 0; i < `BMU_LANES; i++) begin : gLane
    bmuLane bmuLane_inst (
      .clk(clk), .arstN(arstN), .issue(issue[i]), .laneReq(laneReq),
      .retire(retire[i]), .busy(busy[i]), .done(done[i]), .laneRes(laneRes[i])
    );
  end

  bmuCollect bmuCollect_inst (
    .clk(clk), .arstN(arstN), .done(done), .laneRes(laneRes),
    .resAck(resAck), .resReq(resReq), .resData(resData), .retire(retire)
  );

endmodule

`default_nettype wire

// ==== bmu_checker.sv ====
/* Protocol checker for the bit-manipulation unit
   Bound into bmuTop to watch both handshakes and lane occupancy */

`timescale 1ns/1ps
`default_nettype none
`include "bmu_cfg.svh"

module bmuChecker import bmu_pkg::*; (
  input logic                  clk,
  input logic                  arstN,
  input logic                  req,
  input logic                  ack,
  input bmuReq_t               reqData,
  input logic                  resReq,
  input logic                  resAck,
  input bmuRes_t               resData,
  input logic [`BMU_LANES-1:0] issue,
  input logic [`BMU_LANES-1:0] busy
);

  int failCount = 0;                       // Failed assertions so far

  //////////////////////////////////////////////////
  // Input handshake
  //////////////////////////////////////////////////

  ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
    $rose(ack) |-> $past(req))
    else begin
      failCount++;
      $error("ack rose without a pending req");
    end

  reqDataHeld: assert property (@(posedge clk) disable iff (!arstN)
    (req && !ack) |=> $stable(reqData))
    else begin
      failCount++;
      $error("reqData changed before ack");
    end

  //////////////////////////////////////////////////
  // Output handshake
  //////////////////////////////////////////////////

  resDataHeld: assert property (@(posedge clk) disable iff (!arstN)
    resReq |=> (!resReq || $stable(resData)))
    else begin
      failCount++;
      $error("resData changed while resReq high");
    end

  // resAck as seen on the edge that raised resReq
  resReqAfterAckLow: assert property (@(posedge clk) disable iff (!arstN)
    $rose(resReq) |-> !$past(resAck))
    else begin
      failCount++;
      $error("resReq raised while resAck still high");
    end

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////

  issueOneHot: assert property (@(posedge clk) disable iff (!arstN) $onehot0(issue))
    else begin
      failCount++;
      $error("more than one lane issued in a cycle");
    end

  issueFreeLane: assert property (@(posedge clk) disable iff (!arstN)
    (issue & busy) == '0)
    else begin
      failCount++;
      $error("request issued into a busy lane");
    end

endmodule

bind bmuTop bmuChecker bmuChecker_inst (
  .clk(clk), .arstN(arstN), .req(req), .ack(ack), .reqData(reqData),
  .resReq(resReq), .resAck(resAck), .resData(resData),
  .issue(issue), .busy(busy)
);

`default_nettype wire

// ==== bmuTb.sv ====
/* Testbench for the bit-manipulation coprocessor
   Drives both four-phase handshakes, predicts every result from the
   instruction semantics and checks values, order, back-pressure and latency */

`timescale 1ns/1ps
`default_nettype none
`include "bmu_cfg.svh"

module bmuTb import bmu_pkg::*; ();

  typedef enum {
    insSh1add, insSh2add, insSh3add, insAndn, insOrn, insXnor,
    insMin, insMinu, insMax, insMaxu, insRol, insRor,
    insBset, insBclr, insBinv, insBext, insClmul, insClmulr, insClmulh,
    insZexth, insBad,                                      // OP opcode
    insClz, insCtz, insCpop, insSextb, insSexth, insRori, insOrcb, insRev8,
    insBseti, insBclri, insBinvi, insBexti, insBadImm       // OP-IMM opcode
  } tbIns_e;

  localparam int NumIns    = int'(insBadImm) + 1;
  localparam int NumEdge   = 6;
  localparam int NumRand   = 64;
  localparam int NumReq    = 1 + NumIns * NumEdge + 7 * 4 + NumRand + `BMU_LANES + 1;
  localparam int MaxCycles = 40 * NumReq + 200;

  localparam logic [6:0] OpReg = 7'b0110011;
  localparam logic [6:0] OpImm = 7'b0010011;

  // Edge operands, paired by index
  localparam logic [31:0] EdgeA [NumEdge] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
                                              32'h8000_0000, 32'h0000_0000, 32'h1234_5678};
  localparam logic [31:0] EdgeB [NumEdge] = '{32'h0000_0000, 32'hffff_ffff, 32'h0000_0001,
                                              32'hffff_ffff, 32'h8000_0000, 32'h9abc_def1};
  localparam logic [4:0]  EdgeSh [NumEdge] = '{5'd0, 5'd31, 5'd1, 5'd7, 5'd16, 5'd24};
  localparam tbIns_e      ImmIns [7] = '{insBseti, insBclri, insBinvi, insBexti, insRori,
                                         insBad, insBadImm};

  logic    clk, arstN, req, resAck, ack, resReq;
  bmuReq_t reqData;
  bmuRes_t resData;

  bmuRes_t     expQ [$];                   // Scoreboard, request order
  string       nameQ [$];
  int          pushed = 0;
  int          completed = 0;
  int          sent = 0;
  int          resultErrors = 0;
  int          protocolErrors = 0;
  int          cycleCount = 0;
  logic        holdConsumer, stallOn;
  logic [31:0] seed = 32'h850b;

  bmuTop bmuTop_inst (
    .clk(clk), .arstN(arstN), .req(req), .reqData(reqData), .resAck(resAck),
    .ack(ack), .resReq(resReq), .resData(resData)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] encodeInstr(input tbIns_e ins, input logic [4:0] rd,
                                              input logic [4:0] sh);
    logic [6:0] f7;
    logic [4:0] f5;                        // rs2 index, sub-op or shamt
    logic [2:0] f3;
    logic [6:0] opc;
    opc = OpReg;
    f5  = 5'd2;
    case (ins)
      insSh1add: {f7, f3} = {7'b0010000, 3'b010};
      insSh2add: {f7, f3} = {7'b0010000, 3'b100};
      insSh3add: {f7, f3} = {7'b0010000, 3'b110};
      insAndn:   {f7, f3} = {7'b0100000, 3'b111};
      insOrn:    {f7, f3} = {7'b0100000, 3'b110};
      insXnor:   {f7, f3} = {7'b0100000, 3'b100};
      insMin:    {f7, f3} = {7'b0000101, 3'b100};
      insMinu:   {f7, f3} = {7'b0000101, 3'b101};
      insMax:    {f7, f3} = {7'b0000101, 3'b110};
      insMaxu:   {f7, f3} = {7'b0000101, 3'b111};
      insRol:    {f7, f3} = {7'b0110000, 3'b001};
      insRor:    {f7, f3} = {7'b0110000, 3'b101};
      insBset:   {f7, f3} = {7'b0010100, 3'b001};
      insBclr:   {f7, f3} = {7'b0100100, 3'b001};
      insBinv:   {f7, f3} = {7'b0110100, 3'b001};
      insBext:   {f7, f3} = {7'b0100100, 3'b101};
      insClmul:  {f7, f3} = {7'b0000101, 3'b001};
      insClmulr: {f7, f3} = {7'b0000101, 3'b010};
      insClmulh: {f7, f3} = {7'b0000101, 3'b011};
      insZexth:  {f7, f5, f3} = {7'b0000100, 5'd0, 3'b100};
      insClz:    {opc, f7, f5, f3} = {OpImm, 7'b0110000, 5'd0, 3'b001};
      insCtz:    {opc, f7, f5, f3} = {OpImm, 7'b0110000, 5'd1, 3'b001};
      insCpop:   {opc, f7, f5, f3} = {OpImm, 7'b0110000, 5'd2, 3'b001};
      insSextb:  {opc, f7, f5, f3} = {OpImm, 7'b0110000, 5'd4, 3'b001};
      insSexth:  {opc, f7, f5, f3} = {OpImm, 7'b0110000, 5'd5, 3'b001};
      insRori:   {opc, f7, f5, f3} = {OpImm, 7'b0110000, sh, 3'b101};
      insOrcb:   {opc, f7, f5, f3} = {OpImm, 7'b0010100, 5'd7, 3'b101};
      insRev8:   {opc, f7, f5, f3} = {OpImm, 7'b0110100, 5'd24, 3'b101};
      insBseti:  {opc, f7, f5, f3} = {OpImm, 7'b0010100, sh, 3'b001};
      insBclri:  {opc, f7, f5, f3} = {OpImm, 7'b0100100, sh, 3'b001};
      insBinvi:  {opc, f7, f5, f3} = {OpImm, 7'b0110100, sh, 3'b001};
      insBexti:  {opc, f7, f5, f3} = {OpImm, 7'b0100100, sh, 3'b101};
      insBadImm: {opc, f7, f5, f3} = {OpImm, 7'b0110000, 5'd3, 3'b001};  // No such unary
      default:   {f7, f3} = {7'b1111111, 3'b000};                        // Unused funct7
    endcase
    return {f7, f5, 5'd1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] rotateLeft(input logic [31:0] x, input logic [4:0] k);
    return (x << k) | (x >> (6'd32 - k));  // k of 0 shifts the second term out
  endfunction

  // Reference semantics, straight from the ISA text
  function automatic logic [31:0] refValue(input tbIns_e ins, input logic [31:0] a,
                                           input logic [31:0] b, input logic [4:0] sh);
    logic [31:0] r;
    int          n;
    r = '0;
    n = 0;
    case (ins)
      insSh1add: r = (a << 1) + b;
      insSh2add: r = (a << 2) + b;
      insSh3add: r = (a << 3) + b;
      insAndn:   r = a & ~b;
      insOrn:    r = a | ~b;
      insXnor:   r = a ~^ b;
      insMin:    r = ($signed(a) < $signed(b)) ? a : b;
      insMinu:   r = (a < b) ? a : b;
      insMax:    r = ($signed(a) > $signed(b)) ? a : b;
      insMaxu:   r = (a > b) ? a : b;
      insRol:    r = rotateLeft(a, b[4:0]);
      insRor:    r = rotateLeft(a, 5'(6'd32 - b[4:0]));
      insRori:   r = rotateLeft(a, 5'(6'd32 - sh));
      insBset:   r = a | (32'd1 << b[4:0]);
      insBclr:   r = a & ~(32'd1 << b[4:0]);
      insBinv:   r = a ^ (32'd1 << b[4:0]);
      insBext:   r = (a >> b[4:0]) & 32'd1;
      insBseti:  r = a | (32'd1 << sh);
      insBclri:  r = a & ~(32'd1 << sh);
      insBinvi:  r = a ^ (32'd1 << sh);
      insBexti:  r = (a >> sh) & 32'd1;
      insZexth:  r = a & 32'h0000_ffff;
      insSextb:  r = {{24{a[7]}}, a[7:0]};
      insSexth:  r = {{16{a[15]}}, a[15:0]};
      insRev8:   r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      insCpop:   r = $countones(a);
      insClz: begin
        while (n < 32 && !a[31 - n]) n++;
        r = n;
      end
      insCtz: begin
        while (n < 32 && !a[n]) n++;
        r = n;
      end
      insOrcb: begin
        for (int k = 0; k < 4; k++) r[8*k +: 8] = (a[8*k +: 8] != 8'h00) ? 8'hff : 8'h00;
      end
      insClmul: begin
        for (int i = 0; i < 32; i++) if (b[i]) r ^= a << i;
      end
      insClmulh: begin
        for (int i = 1; i < 32; i++) if (b[i]) r ^= a >> (32 - i);
      end
      insClmulr: begin
        for (int i = 0; i < 32; i++) if (b[i]) r ^= a >> (31 - i);
      end
      default: r = '0;                     // Unrecognised encodings
    endcase
    return r;
  endfunction

  // Input four-phase handshake, one request
  task automatic sendRequest(input tbIns_e ins, input logic [31:0] a, input logic [31:0] b,
                             input logic [4:0] sh, input string tag);
    logic [4:0] rd;
    bmuRes_t    exp;
    rd = 5'(nextRand() >> 27);
    exp.rd    = rd;
    exp.value = refValue(ins, a, b, sh);
    @(negedge clk);
    reqData.instr.word = encodeInstr(ins, rd, sh);
    reqData.rs1Val     = a;
    reqData.rs2Val     = b;                // Ignored by immediate forms
    req                = 1'b1;
    expQ.push_back(exp);
    nameQ.push_back({tag, "/", ins.name()});
    pushed++;
    while (!ack) @(negedge clk);
    req = 1'b0;
    while (ack) @(negedge clk);
    sent++;
  endtask

  task automatic waitIdle();
    while (completed != pushed) @(negedge clk);
    repeat (3) @(negedge clk);             // Last lane retires
  endtask

  //////////////////////////////////////////////////
  // Clock, watchdog, consumer
  //////////////////////////////////////////////////

  initial begin : clockGen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin : watchdog
    while (cycleCount < MaxCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, a handshake never completed", MaxCycles);
    $display("Something failed");
    $finish;
  end

  // Output four-phase handshake, checks each result against the scoreboard head
  initial begin : consumer
    bmuRes_t exp;
    string   name;
    int      stall;
    forever begin
      @(negedge clk);
      if (resReq) begin
        while (holdConsumer) @(negedge clk);
        stall = stallOn ? int'(nextRand() >> 29) : 0;
        repeat (stall) @(negedge clk);
        if (expQ.size() == 0) begin
          protocolErrors++;
          $display("Result rd %0d value %h arrived with no request outstanding",
                   resData.rd, resData.value);
        end else begin
          exp  = expQ.pop_front();
          name = nameQ.pop_front();
          assert (resData == exp) else begin
            resultErrors++;
            $display("ERR %s: expected rd %0d value %h, actual rd %0d value %h",
                     name, exp.rd, exp.value, resData.rd, resData.value);
          end
        end
        resAck = 1'b1;
        while (resReq) @(negedge clk);
        resAck = 1'b0;
        completed++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    int     lat;
    int     base;
    int     doneBefore;
    int     checkerErrors;
    tbIns_e ins;
    arstN        = 1'b0;
    req          = 1'b0;
    resAck       = 1'b0;
    reqData      = '0;
    holdConsumer = 1'b0;
    stallOn      = 1'b0;
    repeat (4) @(negedge clk);
    arstN = 1'b1;

    // Idle after reset
    repeat (5) begin
      @(negedge clk);
      assert (!ack && !resReq) else begin
        protocolErrors++;
        $display("ERR reset: expected ack 0 resReq 0, actual ack %b resReq %b", ack, resReq);
      end
    end

    // Latency, lanes empty, consumer answers at once
    fork
      sendRequest(insClmul, 32'h8000_0001, 32'h0000_0003, 5'd0, "latency");
      begin
        @(negedge clk);                    // req driven here
        @(negedge clk);                    // req sampled
        lat = 0;
        while (!resReq) begin
          @(negedge clk);
          lat++;
        end
        assert (lat == 3) else begin
          protocolErrors++;
          $display("ERR latency: expected 3 cycles, actual %0d", lat);
        end
      end
    join
    waitIdle();

    // Every operation on edge operands
    for (int k = 0; k < NumIns; k++) begin
      for (int j = 0; j < NumEdge; j++) begin
        sendRequest(tbIns_e'(k), EdgeA[j], EdgeB[j], EdgeSh[j], "directed");
      end
    end
    waitIdle();

    // Immediate forms with junk rs2Val, plus bad encodings
    for (int k = 0; k < 7; k++) begin
      repeat (4) sendRequest(ImmIns[k], nextRand(), nextRand(), 5'(nextRand() >> 27),
                             "immediate");
    end
    waitIdle();

    // Back-to-back random mix, consumer stalls
    stallOn = 1'b1;
    for (int k = 0; k < NumRand; k++) begin
      ins = tbIns_e'((nextRand() >> 8) % NumIns);
      sendRequest(ins, nextRand(), nextRand(), 5'(nextRand() >> 27), "random");
    end
    waitIdle();
    stallOn = 1'b0;

    // All lanes full, extra request must wait for the first retire
    holdConsumer = 1'b1;
    base         = sent;
    fork
      for (int k = 0; k <= `BMU_LANES; k++) begin
        ins = tbIns_e'((nextRand() >> 8) % NumIns);
        sendRequest(ins, nextRand(), nextRand(), 5'(nextRand() >> 27), "backpressure");
      end
      begin
        while (sent < base + `BMU_LANES) @(negedge clk);
        repeat (12) begin
          @(negedge clk);
          assert (!ack) else begin
            protocolErrors++;
            $display("ERR backpressure: expected ack 0, actual %b", ack);
          end
        end
        doneBefore   = completed;
        holdConsumer = 1'b0;
        while (!ack) @(negedge clk);
        assert (completed > doneBefore) else begin
          protocolErrors++;
          $display("Extra request was acked before any result finished its handshake");
        end
      end
    join
    waitIdle();

    checkerErrors = bmuTop_inst.bmuChecker_inst.failCount;
    $display("Errors: result %0d, protocol %0d, assertion %0d",
             resultErrors, protocolErrors, checkerErrors);
    if (resultErrors + protocolErrors + checkerErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
bmu_pkg.sv
bitCount.sv
bitmanipAlu.sv
bmuLane.sv
bmuDispatch.sv
bmuCollect.sv
bmuTop.sv
bmu_checker.sv
bmuTb.sv
